/* filelist.f */
verilog/uart_pkg.sv
verilog/uart_byte_if.sv
verilog/uart_apb_regs.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
dv/uart_props.sv
dv/uart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module uart_tb -f filelist.f &&
./obj_dir/Vuart_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run_sim: pass" ||
{ echo "run_sim: fail"; exit 1; }

/* dv/uart_tb.sv */
`default_nettype none

module uart_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    typedef struct packed {
        logic [7:0] data;
        logic       odd;                // CTRL parity select
        logic       inject;             // Line driver instead of loopback
        logic       corrupt;            // Flip the injected parity bit
    } stim_t;

    localparam int clk_period  = 8;
    localparam int num_entries = 16;
    // Four frame times per entry plus a back-pressure slot and margin
    localparam int watchdog_ns = (num_entries + 1) * 4 * frame_bits * clks_per_bit * clk_period
                                 + 2000;

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [3:0]            paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  tx_w;
    logic                  rx_w;
    logic                  inject_mode;     // 0 loops tx back to rx
    logic                  line_drv;        // Injected rx level
    logic [frame_bits-1:0] mon_q [$];       // Frames seen on tx with bit 0 first on the line
    stim_t                 stim [num_entries];
    integer                seed;

    uart_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .tx      (tx_w),
        .rx      (rx_w)
    );

    assign rx_w = inject_mode ? line_drv : tx_w;

    always #(clk_period / 2) clk = ~clk;

    // Parity bit that brings the ones count to even, or to odd when selected
    function automatic logic parity_for(input logic [7:0] data, input logic odd);
        logic p;
        p = 1'b0;
        if (($countones({data, p}) % 2) != int'(odd))
            p = 1'b1;
        return p;
    endfunction

    function automatic logic [frame_bits-1:0] frame_for(input logic [7:0] data, input logic odd,
                                                       input logic corrupt);
        return {1'b1, parity_for(data, odd) ^ corrupt, data, 1'b0};   // Stop .. start
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // Both APB tasks start and end on a falling edge
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        psel    = 1'b1;                 // Setup cycle
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;                 // Access cycle
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(clk_period / 4);              // Sampled mid access cycle
        data    = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_tx_idle();
        logic [31:0] rd;
        do
            apb_read(addr_status, rd);
        while (rd[status_tx_busy_bit]);
    endtask

    task automatic wait_rx_valid(output logic [31:0] rd);
        do
            apb_read(addr_status, rd);
        while (!rd[status_rx_valid_bit]);
    endtask

    task automatic drive_frame(input logic [frame_bits-1:0] f);
        for (int i = 0; i < frame_bits; i++)
        begin
            line_drv = f[i];
            repeat (clks_per_bit) @(negedge clk);
        end
    endtask

    task automatic build_stimulus();
        logic [31:0] r;
        stim[0] = '{8'h55, 1'b0, 1'b0, 1'b0};
        stim[1] = '{8'ha3, 1'b1, 1'b0, 1'b0};
        stim[2] = '{8'h00, 1'b1, 1'b0, 1'b0};
        stim[3] = '{8'hff, 1'b0, 1'b0, 1'b0};
        stim[4] = '{8'h3c, 1'b0, 1'b1, 1'b0};
        stim[5] = '{8'h81, 1'b1, 1'b1, 1'b1};
        stim[6] = '{8'h7e, 1'b0, 1'b1, 1'b1};
        stim[7] = '{8'h96, 1'b1, 1'b1, 1'b0};
        for (int i = 8; i < num_entries; i++)
        begin
            r = $random(seed);
            stim[i] = '{r[7:0], r[8], r[9], r[9] & r[10]};   // Corrupt only injected frames
        end
    endtask

    task automatic run_entry(input stim_t e);
        logic [31:0] rd;
        apb_write(addr_ctrl, {31'd0, e.odd});
        apb_read(addr_ctrl, rd);
        check_eq("ctrl", rd, {31'd0, e.odd});
        if (e.inject)
        begin
            inject_mode = 1'b1;
            drive_frame(frame_for(e.data, e.odd, e.corrupt));
        end
        else
        begin
            inject_mode = 1'b0;
            mon_q.delete();
            apb_write(addr_data, {24'd0, e.data});
            apb_read(addr_status, rd);
            check_eq("status.tx_busy", {31'd0, rd[status_tx_busy_bit]}, 32'd1);
            wait_tx_idle();
            check_eq("monitor frame count", 32'(mon_q.size()), 32'd1);
            check_eq("tx frame", 32'(mon_q[0]), 32'(frame_for(e.data, e.odd, 1'b0)));
        end
        wait_rx_valid(rd);
        check_eq("status.parity_err", {31'd0, rd[status_parity_err_bit]}, {31'd0, e.corrupt});
        apb_read(addr_data, rd);
        check_eq("data", rd, {24'd0, e.data});
        apb_read(addr_status, rd);
        check_eq("status after data read", rd, 32'd0);  // rx_valid and parity_err gone
    endtask

    task automatic check_back_pressure();
        logic [31:0] rd;
        inject_mode = 1'b0;
        mon_q.delete();
        apb_write(addr_ctrl, 32'd0);
        apb_write(addr_data, 32'h0000_00c5);
        apb_write(addr_data, 32'h0000_003a);   // Lands while tx_busy is set
        wait_tx_idle();
        check_eq("monitor frame count", 32'(mon_q.size()), 32'd1);
        check_eq("tx frame", 32'(mon_q[0]), 32'(frame_for(8'hc5, 1'b0, 1'b0)));
        wait_rx_valid(rd);
        apb_read(addr_data, rd);
        check_eq("data", rd, 32'h0000_00c5);
        repeat (frame_bits * clks_per_bit) @(negedge clk);   // Room for a stray frame
        check_eq("monitor frame count", 32'(mon_q.size()), 32'd1);
    endtask

    // Line monitor sampling each bit near its middle
    initial
    begin
        logic [frame_bits-1:0] f;
        forever
        begin
            @(negedge tx_w);
            repeat (half_bit) @(negedge clk);
            for (int i = 0; i < frame_bits; i++)
            begin
                if (i > 0)
                    repeat (clks_per_bit) @(negedge clk);
                f[i] = tx_w;
            end
            mon_q.push_back(f);
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the run hung before all table entries were applied");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial
    begin
        logic [31:0] rd;
        clk         = 1'b0;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 4'h0;
        pwdata      = 32'd0;
        inject_mode = 1'b0;
        line_drv    = 1'b1;             // Idle line
        seed        = 32'h3696e70f;
        build_stimulus();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_eq("tx", {31'd0, tx_w}, 32'd1);
        apb_read(addr_status, rd);
        check_eq("status", rd, 32'd0);
        apb_read(addr_ctrl, rd);
        check_eq("ctrl", rd, 32'd0);
        for (int i = 0; i < num_entries; i++)
            run_entry(stim[i]);
        check_back_pressure();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/uart_props.sv */
`default_nettype none

module uart_props (
    input wire       clk,
    input wire       reset,
    input wire       psel,
    input wire       penable,
    input wire       pwrite,
    input wire [3:0] paddr,
    input wire       tx,
    input wire       tx_busy_line,      // Serializer not idle
    input wire       tx_hold            // TX holding register full
);

    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    logic write_accepted;               // DATA write into an idle transmitter

    assign write_accepted = psel && penable && pwrite && (paddr == addr_data)
                            && !(tx_hold || tx_busy_line);

    reset_holds_line: assert property (@(posedge clk) reset |=> tx)
        else $error("tx low during reset or on the cycle after it");

    idle_line_high: assert property (@(posedge clk) disable iff (reset) !tx_busy_line |-> tx)
        else $error("tx low while the serializer is idle");

    // Hold register fills, handshake, then the start bit
    start_after_write: assert property (@(posedge clk) disable iff (reset)
        $past(write_accepted, 2) |-> !tx)
        else $error("no start bit within three cycles of a DATA write");

endmodule

bind uart_top uart_props props_i (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .tx           (tx),
    .tx_busy_line (tx_busy_line),
    .tx_hold      (tx_link.valid)
);

`default_nettype wire

/* verilog/uart_top.sv */
`default_nettype none

module uart_top (
    input  wire         clk,
    input  wire         reset,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [3:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        tx,
    input  wire         rx
);

    logic tx_busy_line;                 // Serializer not idle

    uart_byte_if tx_link ();            // Registers to serializer
    uart_byte_if rx_link ();            // Deserializer to registers

    uart_apb_regs regs_i (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .tx_busy_line (tx_busy_line),
        .tx_out       (tx_link.tx_src),
        .rx_in        (rx_link.rx_dst)
    );

    uart_tx tx_i (
        .clk     (clk),
        .reset   (reset),
        .byte_in (tx_link.tx_dst),
        .tx      (tx),
        .busy    (tx_busy_line)
    );

    uart_rx rx_i (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .byte_out (rx_link.rx_src)
    );

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
`default_nettype none

module uart_rx (
    input  wire         clk,
    input  wire         reset,
    input  wire         rx,
    uart_byte_if.rx_src byte_out
);

    import uart_pkg::*;

    rx_state_e        state;
    logic [1:0]       rx_sync;          // Two-flop synchronizer
    logic             rx_s;             // Synchronized line
    logic [cnt_w-1:0] clk_cnt;          // Cycles since last sample point
    logic [2:0]       bit_cnt;          // Data bit index
    logic [7:0]       shift_reg;        // Data, LSB arrives first
    logic             parity_rx;        // Received parity bit
    logic             valid_q;
    logic             full_bit;         // One bit period since last sample
    logic             mid_start;        // Middle of the start bit

    assign rx_s      = rx_sync[1];
    assign full_bit  = (clk_cnt == cnt_w'(clks_per_bit - 1));
    assign mid_start = (clk_cnt == cnt_w'(half_bit - 1));

    assign byte_out.valid = valid_q;
    assign byte_out.data  = shift_reg;
    // Ones across data and parity must be even, or odd when selected
    assign byte_out.parity_error = (^{shift_reg, parity_rx}) ^ byte_out.odd_parity;

    always_ff @(posedge clk)
    begin
        if (reset)
            rx_sync <= 2'b11;           // Line idles high
        else
            rx_sync <= {rx_sync[0], rx};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= rx_idle;
            clk_cnt <= '0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;            // One-cycle pulse
            case (state)
                rx_idle:
                begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rx_s)
                        state <= rx_start;  // First low sample
                end
                rx_start:
                begin
                    if (mid_start)
                    begin
                        clk_cnt <= '0;  // Later samples are one period apart
                        if (rx_s)
                            state <= rx_idle;  // Glitch, not a start bit
                        else
                            state <= rx_bits;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_bits:
                begin
                    if (full_bit)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= rx_parity;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_parity:
                begin
                    if (full_bit)
                    begin
                        clk_cnt <= '0;
                        state   <= rx_stop;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_stop:
                begin
                    if (full_bit)
                    begin
                        clk_cnt <= '0;
                        valid_q <= rx_s;    // Low stop bit drops the frame
                        state   <= rx_idle;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Payload capture at the data and parity sample points
    always_ff @(posedge clk)
    begin
        if (state == rx_bits && full_bit)
            shift_reg <= {rx_s, shift_reg[7:1]};
        if (state == rx_parity && full_bit)
            parity_rx <= rx_s;
    end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`default_nettype none

module uart_tx (
    input  wire         clk,
    input  wire         reset,
    uart_byte_if.tx_dst byte_in,
    output logic        tx,
    output logic        busy
);

    import uart_pkg::*;

    tx_state_e              state;
    logic [frame_bits-1:0]  frame;      // Bit 0 is on the line
    logic [cnt_w-1:0]       clk_cnt;    // Cycles within the current bit
    logic [frame_cnt_w-1:0] bit_cnt;    // Index of the bit on the line
    logic                   parity_bit;
    logic                   bit_end;    // Last cycle of a bit
    logic                   take;       // Handshake

    assign byte_in.ready = (state == tx_idle);   // Ready only while idle
    assign busy          = (state != tx_idle);
    assign take          = byte_in.valid && byte_in.ready;

    // Even parity is the XOR of the data, odd flips it
    assign parity_bit = (^byte_in.data) ^ byte_in.odd_parity;

    assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));

    // Line driven straight from the shift register flop
    assign tx = frame[0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= tx_idle;
            frame   <= '1;              // Idle line high
            clk_cnt <= '0;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                tx_idle:
                begin
                    if (take)
                    begin
                        // Stop, parity, data LSB first, start
                        frame   <= {1'b1, parity_bit, byte_in.data, 1'b0};
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= tx_shift;
                    end
                end
                tx_shift:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        frame   <= {1'b1, frame[frame_bits-1:1]};  // Shift in idle ones
                        if (bit_cnt == frame_cnt_w'(frame_bits - 1))
                            state <= tx_idle;  // Stop bit done
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_apb_regs.sv */
`default_nettype none

module uart_apb_regs (
    input  wire         clk,
    input  wire         reset,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [3:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    input  wire         tx_busy_line,   // Serializer not idle
    uart_byte_if.tx_src tx_out,
    uart_byte_if.rx_dst rx_in
);

    import uart_pkg::*;

    logic       access;                 // APB access phase
    logic       wr_data;
    logic       wr_ctrl;
    logic       rd_data;
    logic       odd_parity;             // CTRL bit 0
    logic       tx_hold_valid;          // TX holding register full
    logic [7:0] tx_hold_data;
    logic       rx_hold_valid;          // RX holding register full
    logic [7:0] rx_hold_data;
    logic       rx_parity_err;          // Belongs to rx_hold_data
    logic       tx_busy;
    logic       tx_fire;                // TX handshake
    logic       rx_fire;                // RX handshake

    assign access  = psel && penable;
    assign wr_data = access && pwrite && (paddr == addr_data);
    assign wr_ctrl = access && pwrite && (paddr == addr_ctrl);
    assign rd_data = access && !pwrite && (paddr == addr_data);

    // Busy until the holding register drains and the frame is out
    assign tx_busy = tx_hold_valid || tx_busy_line;

    assign tx_out.valid      = tx_hold_valid;
    assign tx_out.data       = tx_hold_data;
    assign tx_out.odd_parity = odd_parity;
    assign tx_fire           = tx_out.valid && tx_out.ready;

    assign rx_in.ready       = !rx_hold_valid;   // Take a byte only when empty
    assign rx_in.odd_parity  = odd_parity;
    assign rx_fire           = rx_in.valid && rx_in.ready;

    // Control register
    always_ff @(posedge clk)
    begin
        if (reset)
            odd_parity <= 1'b0;
        else if (wr_ctrl)
            odd_parity <= pwdata[0];
    end

    // TX holding register, write ignored while busy
    always_ff @(posedge clk)
    begin
        if (reset)
            tx_hold_valid <= 1'b0;
        else if (wr_data && !tx_busy)
            tx_hold_valid <= 1'b1;
        else if (tx_fire)
            tx_hold_valid <= 1'b0;      // Serializer took it
    end

    always_ff @(posedge clk)
    begin
        if (wr_data && !tx_busy)
            tx_hold_data <= pwdata[7:0];  // Payload only, no reset
    end

    // RX holding register with its parity flag
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_hold_valid <= 1'b0;
            rx_parity_err <= 1'b0;
        end
        else if (rx_fire)
        begin
            rx_hold_valid <= 1'b1;
            rx_parity_err <= rx_in.parity_error;
        end
        else if (rd_data)
        begin
            rx_hold_valid <= 1'b0;      // Read consumes the byte
            rx_parity_err <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_fire)
            rx_hold_data <= rx_in.data;   // Stays readable after valid clears
    end

    // Read mux, live only in the access cycle
    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            case (paddr)
                addr_data:   prdata[7:0] = rx_hold_data;
                addr_status:
                begin
                    prdata[status_tx_busy_bit]    = tx_busy;
                    prdata[status_rx_valid_bit]   = rx_hold_valid;
                    prdata[status_parity_err_bit] = rx_parity_err;
                end
                addr_ctrl:   prdata[0] = odd_parity;
                default:     prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_byte_if.sv */
`default_nettype none

interface uart_byte_if;

    logic       valid;           // Source has a byte
    logic       ready;           // Sink can take it
    logic [7:0] data;
    logic       odd_parity;      // Parity select, always from the register block
    logic       parity_error;    // Only meaningful on the rx path

    // Register block sending to the serializer
    modport tx_src (output valid, output data, output odd_parity, input ready);
    modport tx_dst (input valid, input data, input odd_parity, output ready);

    // Deserializer offering to the register block; no back-pressure, byte dropped if not ready
    modport rx_src (output valid, output data, output parity_error, input odd_parity);
    modport rx_dst (input valid, input data, input parity_error,
                    output ready, output odd_parity);

endinterface

`default_nettype wire

/* verilog/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // Serial timing
    localparam int clks_per_bit = 10;                  // Clock cycles per serial bit
    localparam int half_bit     = clks_per_bit / 2;    // Mid-bit sample point
    localparam int cnt_w        = $clog2(clks_per_bit); // Bit-period counter width

    // Frame layout
    localparam int frame_bits   = 11;                  // Start + 8 data + parity + stop
    localparam int data_bits    = 8;
    localparam int frame_cnt_w  = $clog2(frame_bits);  // Frame bit index width

    // Status word bit positions
    localparam int status_tx_busy_bit    = 0;
    localparam int status_rx_valid_bit   = 1;
    localparam int status_parity_err_bit = 2;

    // Register offsets on paddr[3:0]
    typedef enum logic [3:0] {
        addr_data   = 4'h0,          // TX write, RX read
        addr_status = 4'h4,          // Read only
        addr_ctrl   = 4'h8           // Parity select
    } reg_addr_e;

    // Receiver FSM
    typedef enum logic [2:0] {
        rx_idle,                     // Waiting for falling edge
        rx_start,                    // Confirming start bit
        rx_bits,                     // Eight data bits
        rx_parity,                   // Parity bit
        rx_stop                      // Stop bit check
    } rx_state_e;

    // Transmitter FSM
    typedef enum logic {
        tx_idle,
        tx_shift
    } tx_state_e;

endpackage

`default_nettype wire
